// ==== dptx_pkg.sv ====
package dptx_pkg;

    // One word on the message chain
    typedef struct packed
    {
        logic           som;            // Start of message
        logic           eom;            // End of message
        logic [15:0]    dat;            // Target ID in low byte on header
        logic           vld;
    } msg_t;

    // Egress payload word, numbered within the message
    typedef struct packed
    {
        logic [4:0]     idx;            // Payload index, header excluded
        logic           first;
        logic           last;           // Word that carried eom
        logic [15:0]    dat;
        logic           vld;
    } egr_t;

    // Control bundle towards the lane stage
    typedef struct packed
    {
        logic [1:0]     lanes;          // 1 one lane, 2 two lanes, 3 four lanes
        logic           trn_sel;        // Training select
        logic [1:0]     vid_en;         // Video stream enables
        logic           mst;
        logic           scrm_en;
        logic [5:0]     vc0_len;        // Virtual channel lengths
        logic [5:0]     vc1_len;
    } ctl_t;

    // Register index carried in egr.idx
    typedef enum logic [4:0] {REG_MASK = 5'd0, REG_CTL = 5'd1, REG_VC_LEN = 5'd2} reg_idx_e;

    // Bit positions in the control and mask registers
    typedef enum logic [2:0]
    {
        CTL_LANES   = 3'd0,             // Two bits wide
        CTL_TRN_SEL = 3'd2,
        CTL_VID0_EN = 3'd3,
        CTL_VID1_EN = 3'd4,
        CTL_MST     = 3'd5,
        CTL_SCRM_EN = 3'd6
    } ctl_bit_e;

    localparam int          CTL_WIDTH = 7;
    localparam logic [15:0] SCRM_SEED = 16'hffff;  // Scrambler restart value
    localparam logic [15:0] SCRM_TAPS = 16'h0039;  // x^16 + x^5 + x^4 + x^3 + 1

endpackage

// ==== dp_msg_egress.sv ====
`timescale 1ns/10ps

module dp_msg_egress
#(
    parameter int P_ID = 0              // ID this slave answers to
)
(
    input  wire logic       RST_IN,     // Clock
    input  wire logic       CLK_IN,     // Async reset, active high
    input  dptx_pkg::msg_t  msg_in,     // Chain in
    output dptx_pkg::msg_t  msg_out,    // Chain out, one cycle later
    output dptx_pkg::egr_t  egr         // Payload words for this ID
);

    // Message tracking
    typedef enum logic [1:0] {ST_IDLE, ST_SEL, ST_SKIP} state_e;

    state_e     state;
    logic [4:0] idx_cnt;                // Running payload index
    logic       hdr_hit;                // Header addresses this slave

    assign hdr_hit = (msg_in.dat[7:0] == 8'(P_ID));

    // Chain forwarding, every word passes through
    always_ff @(posedge RST_IN or posedge CLK_IN)
    begin
        if (CLK_IN)
            msg_out <= '0;
        else
            msg_out <= msg_in;
    end

    always_ff @(posedge RST_IN or posedge CLK_IN)
    begin
        if (CLK_IN)
        begin
            state   <= ST_IDLE;
            idx_cnt <= '0;
            egr     <= '0;
        end
        else
        begin
            egr.vld <= 1'b0;            // Single cycle strobe
            if (msg_in.vld)
            begin
                if (msg_in.som)
                begin
                    // Header word, a new message always restarts tracking
                    idx_cnt <= '0;
                    if (msg_in.eom)
                        state <= ST_IDLE;   // Header only, nothing to hand out
                    else if (hdr_hit)
                        state <= ST_SEL;
                    else
                        state <= ST_SKIP;
                end
                else
                begin
                    if (state == ST_SEL)
                    begin
                        egr.idx   <= idx_cnt;
                        egr.first <= (idx_cnt == 5'd0);
                        egr.last  <= msg_in.eom;
                        egr.dat   <= msg_in.dat;
                        egr.vld   <= 1'b1;
                        idx_cnt   <= idx_cnt + 5'd1;
                    end
                    if (msg_in.eom)
                        state <= ST_IDLE;   // Message done
                end
            end
        end
    end

endmodule

// ==== dptx_ctl.sv ====
`timescale 1ns/10ps

module dptx_ctl
#(
    parameter bit P_MST = 1'b0          // Build VC length register
)
(
    input  wire logic       RST_IN,     // Clock
    input  wire logic       CLK_IN,     // Async reset
    input  dptx_pkg::egr_t  egr,
    output dptx_pkg::ctl_t  ctl
);

    logic [dptx_pkg::CTL_WIDTH-1:0] msk_r;  // Write mask
    logic [dptx_pkg::CTL_WIDTH-1:0] ctl_r;  // Control register
    logic [11:0]                    vc_len; // {vc1, vc0}
    logic                           wr_msk;
    logic                           wr_ctl;
    logic                           wr_vc;

    // Register select from payload index
    assign wr_msk = egr.vld && (egr.idx == dptx_pkg::REG_MASK);
    assign wr_ctl = egr.vld && (egr.idx == dptx_pkg::REG_CTL);
    assign wr_vc  = egr.vld && (egr.idx == dptx_pkg::REG_VC_LEN);

    // Mask register
    always_ff @(posedge RST_IN or posedge CLK_IN)
    begin
        if (CLK_IN)
            msk_r <= '0;
        else if (wr_msk)
            msk_r <= egr.dat[dptx_pkg::CTL_WIDTH-1:0];
    end

    // Control register, unmasked bits keep their value
    always_ff @(posedge RST_IN or posedge CLK_IN)
    begin
        if (CLK_IN)
            ctl_r <= '0;
        else if (wr_ctl)
            ctl_r <= (ctl_r & ~msk_r) | (egr.dat[dptx_pkg::CTL_WIDTH-1:0] & msk_r);
    end

    // VC lengths, MST builds only
    generate
        if (P_MST)
        begin : gen_vc_len
            always_ff @(posedge RST_IN or posedge CLK_IN)
            begin
                if (CLK_IN)
                    vc_len <= '0;
                else if (wr_vc)
                    vc_len <= {egr.dat[13:8], egr.dat[5:0]};
            end
        end
        else
        begin : gen_no_vc_len
            assign vc_len = '0;         // SST, lengths read zero
        end
    endgenerate

    // Unpack into the bundle
    always_comb
    begin
        ctl.lanes   = ctl_r[dptx_pkg::CTL_LANES +: 2];
        ctl.trn_sel = ctl_r[dptx_pkg::CTL_TRN_SEL];
        ctl.vid_en  = {ctl_r[dptx_pkg::CTL_VID1_EN], ctl_r[dptx_pkg::CTL_VID0_EN]};
        ctl.mst     = ctl_r[dptx_pkg::CTL_MST];
        ctl.scrm_en = ctl_r[dptx_pkg::CTL_SCRM_EN];
        ctl.vc0_len = vc_len[5:0];
        ctl.vc1_len = vc_len[11:6];
    end

endmodule

// ==== dptx_lane_scrm.sv ====
`timescale 1ns/10ps

module dptx_lane_scrm
(
    input  wire logic        RST_IN,        // Clock
    input  wire logic        CLK_IN,        // Async reset
    input  dptx_pkg::ctl_t   ctl,
    input  wire logic [31:0] lane_dat_in,   // Lane 0 in bits 7..0
    input  wire logic        lane_vld_in,
    output logic [31:0]      lane_dat_out,
    output logic             lane_vld_out
);

    logic [15:0] scrm_q;                // Scrambler state
    logic [15:0] scrm_nxt;              // State after eight steps
    logic [7:0]  scrm_key;              // Output bits for this cycle
    logic [3:0]  lane_en;               // Active lane decode
    logic        scrm_on;
    logic        scrm_hold;             // Keep state at seed
    logic [31:0] lane_dat;

    // One serial step, output bit is the top bit
    function automatic logic [15:0] scrm_step(input logic [15:0] s);
        logic [15:0] r;
        r = {s[14:0], 1'b0};
        if (s[15])
            r = r ^ dptx_pkg::SCRM_TAPS;
        return r;
    endfunction

    assign scrm_on   = ctl.scrm_en && !ctl.trn_sel;   // Training data not scrambled
    assign scrm_hold = ctl.trn_sel || !ctl.scrm_en;

    // Eight steps per byte, first bit lands in bit 0
    always_comb
    begin
        scrm_nxt = scrm_q;
        for (int i = 0; i < 8; i++)
        begin
            scrm_key[i] = scrm_nxt[15];
            scrm_nxt    = scrm_step(scrm_nxt);
        end
    end

    always_ff @(posedge RST_IN or posedge CLK_IN)
    begin
        if (CLK_IN)
            scrm_q <= dptx_pkg::SCRM_SEED;
        else if (scrm_hold)
            scrm_q <= dptx_pkg::SCRM_SEED;  // Restart sequence
        else if (lane_vld_in)
            scrm_q <= scrm_nxt;
    end

    // Lane count decode
    always_comb
    begin
        case (ctl.lanes)
            2'd1:    lane_en = 4'b0001;
            2'd2:    lane_en = 4'b0011;
            2'd3:    lane_en = 4'b1111;
            default: lane_en = 4'b0000;     // No lanes
        endcase
    end

    // Same key on every active lane
    always_comb
    begin
        for (int l = 0; l < 4; l++)
        begin
            if (!lane_en[l])
                lane_dat[l*8 +: 8] = 8'h00;
            else if (scrm_on)
                lane_dat[l*8 +: 8] = lane_dat_in[l*8 +: 8] ^ scrm_key;
            else
                lane_dat[l*8 +: 8] = lane_dat_in[l*8 +: 8];
        end
    end

    always_ff @(posedge RST_IN)
    begin
        lane_dat_out <= lane_dat;       // Registered lane bytes
    end

    always_ff @(posedge RST_IN or posedge CLK_IN)
    begin
        if (CLK_IN)
            lane_vld_out <= 1'b0;
        else
            lane_vld_out <= lane_vld_in;
    end

endmodule

// ==== dptx_top.sv ====
`timescale 1ns/10ps

module dptx_top
#(
    parameter int P_ID  = 3,            // Message chain ID
    parameter bit P_MST = 1'b1          // MST support
)
(
    input  wire logic        RST_IN,    // Clock
    input  wire logic        CLK_IN,    // Async reset, active high
    input  dptx_pkg::msg_t   msg_in,    // From host
    output dptx_pkg::msg_t   msg_out,   // Down the chain
    output dptx_pkg::ctl_t   ctl,
    input  wire logic [31:0] lane_dat_in,
    input  wire logic        lane_vld_in,
    output logic [31:0]      lane_dat_out,
    output logic             lane_vld_out
);

    dptx_pkg::egr_t egr;                // Selected payload words

    dp_msg_egress
    #(
        .P_ID           (P_ID)
    )
    i_egress
    (
        .RST_IN         (RST_IN),
        .CLK_IN         (CLK_IN),
        .msg_in         (msg_in),
        .msg_out        (msg_out),
        .egr            (egr)
    );

    dptx_ctl
    #(
        .P_MST          (P_MST)
    )
    i_ctl
    (
        .RST_IN         (RST_IN),
        .CLK_IN         (CLK_IN),
        .egr            (egr),
        .ctl            (ctl)
    );

    dptx_lane_scrm i_lane
    (
        .RST_IN         (RST_IN),
        .CLK_IN         (CLK_IN),
        .ctl            (ctl),
        .lane_dat_in    (lane_dat_in),
        .lane_vld_in    (lane_vld_in),
        .lane_dat_out   (lane_dat_out),
        .lane_vld_out   (lane_vld_out)
    );

endmodule

// ==== dptx_asserts.sv ====
`timescale 1ns/10ps

module dptx_asserts
(
    input wire logic        RST_IN,     // Clock
    input wire logic        CLK_IN,     // Async reset
    input dptx_pkg::msg_t   msg_in,
    input dptx_pkg::msg_t   msg_out,
    input dptx_pkg::ctl_t   ctl,
    input wire logic        lane_vld_in,
    input wire logic        lane_vld_out
);

    // Chain output is last cycle's input
    a_msg_fwd : assert property (@(posedge RST_IN) disable iff (CLK_IN)
        msg_out == $past(msg_in))
        else $error("msg_out differs from msg_in of the previous cycle");

    a_ctl_known : assert property (@(posedge RST_IN) disable iff (CLK_IN)
        !$isunknown(ctl))
        else $error("ctl holds unknown bits");

    // One cycle lane latency
    a_vld_follow : assert property (@(posedge RST_IN) disable iff (CLK_IN)
        lane_vld_out == $past(lane_vld_in))
        else $error("lane_vld_out does not follow lane_vld_in");

endmodule

bind dptx_top dptx_asserts i_asserts
(
    .RST_IN         (RST_IN),
    .CLK_IN         (CLK_IN),
    .msg_in         (msg_in),
    .msg_out        (msg_out),
    .ctl            (ctl),
    .lane_vld_in    (lane_vld_in),
    .lane_vld_out   (lane_vld_out)
);

// ==== tb_dptx.sv ====
`timescale 1ns/10ps

module tb_dptx;

    localparam int DUT_ID = 3;
    localparam bit MST_ON = 1'b1;

    logic           RST_IN = 1'b0;          // Clock, 20 ns
    logic           CLK_IN;                 // Async reset
    dptx_pkg::msg_t msg_in;
    dptx_pkg::msg_t msg_out;
    dptx_pkg::ctl_t ctl;
    logic [31:0]    lane_dat_in;
    logic           lane_vld_in;
    logic [31:0]    lane_dat_out;
    logic           lane_vld_out;

    logic [15:0]    lfsr = 16'd69;          // Stimulus source
    logic [15:0]    payload [0:3];
    logic [6:0]     mdl_msk = '0;           // Control model state
    logic [6:0]     mdl_reg = '0;
    logic [11:0]    mdl_vc = '0;            // {vc1, vc0}
    dptx_pkg::ctl_t mdl_ctl = '0;           // Settled ctl as the lane model sees it
    logic [15:0]    mdl_scrm;
    logic [23:0]    scrm_res;               // {key, next state}
    logic [31:0]    exp_dat;
    logic           exp_vld;
    dptx_pkg::msg_t exp_msg;
    logic           exp_ok = 1'b0;
    int             err_main = 0;
    int             err_cmp = 0;
    int             tmo = 0;

    dptx_top
    #(
        .P_ID           (DUT_ID),
        .P_MST          (MST_ON)
    )
    i_dut
    (
        .RST_IN         (RST_IN),
        .CLK_IN         (CLK_IN),
        .msg_in         (msg_in),
        .msg_out        (msg_out),
        .ctl            (ctl),
        .lane_dat_in    (lane_dat_in),
        .lane_vld_in    (lane_vld_in),
        .lane_dat_out   (lane_dat_out),
        .lane_vld_out   (lane_vld_out)
    );

    always #10 RST_IN = ~RST_IN;

    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [31:0] rnd(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // Control register fields by bit position
    function automatic dptx_pkg::ctl_t ctl_model(input logic [6:0] r, input logic [11:0] vc);
        dptx_pkg::ctl_t c;
        c         = '0;
        c.lanes   = r[1:0];
        c.trn_sel = r[2];
        c.vid_en  = r[4:3];                 // {vid1, vid0}
        c.mst     = r[5];
        c.scrm_en = r[6];
        if (MST_ON)
            {c.vc1_len, c.vc0_len} = vc;    // Zero in SST builds
        return c;
    endfunction

    // DP scrambler x^16 + x^5 + x^4 + x^3 + 1, eight steps per byte
    function automatic logic [23:0] scrm_model(input logic [15:0] s);
        logic [7:0] key;
        logic       o;
        for (int i = 0; i < 8; i++)
        begin
            o      = s[15];
            key[i] = o;                     // First bit out to bit 0
            s      = {s[14:0], 1'b0} ^ {10'b0, o, o, o, 2'b0, o};
        end
        return {key, s};
    endfunction

    task automatic next_cycle();
        @(posedge RST_IN);
        #1;                                 // Drive just after the edge
    endtask

    task automatic report(input string name, input logic [31:0] got, input logic [31:0] want,
                          inout int cnt);
        cnt++;
        $display("Fail %s got %h expected %h", name, got, want);
    endtask

    // Header then n payload words, random idle gaps
    task automatic send_msg(input logic [7:0] id, input int n);
        logic [31:0] t;
        msg_in = '{1'b1, n == 0, {8'h00, id}, 1'b1};
        next_cycle();
        for (int i = 0; i < n; i++)
        begin
            t = rnd(1);
            if (t[0])
            begin
                msg_in = '0;                // Idle cycle inside the message
                next_cycle();
            end
            msg_in = '{1'b0, i == n - 1, payload[i], 1'b1};
            next_cycle();
        end
        msg_in = '0;
    endtask

    // Write to this ID, update the model, wait for ctl
    task automatic write_regs(input int n);
        dptx_pkg::ctl_t exp_ctl;
        int             k;
        send_msg(8'(DUT_ID), n);
        if (n > 0)
            mdl_msk = payload[0][6:0];
        if (n > 1)
        begin
            for (int b = 0; b < 7; b++)
            begin
                if (mdl_msk[b])
                    mdl_reg[b] = payload[1][b]; // Only masked bits take the new value
            end
        end
        if (n > 2)
            mdl_vc = {payload[2][13:8], payload[2][5:0]};
        exp_ctl = ctl_model(mdl_reg, mdl_vc);
        k = 0;
        while (ctl !== exp_ctl && k < 1)    // Two cycles after the last word
        begin
            next_cycle();
            k++;
        end
        if (ctl !== exp_ctl)
        begin
            tmo++;
            $display("Timeout waiting for ctl to take the written value");
        end
        assert (ctl == exp_ctl)
        else report("ctl", 32'(ctl), 32'(exp_ctl), err_main);
        mdl_ctl = exp_ctl;
        next_cycle();                       // Scrambler settles first
    endtask

    task automatic drive_lanes(input int cycles, input bit gaps);
        logic [31:0] t;
        for (int i = 0; i < cycles; i++)
        begin
            lane_dat_in = rnd(32);
            t           = rnd(1);
            lane_vld_in = t[0] | ~gaps;
            next_cycle();
        end
        lane_vld_in = 1'b0;
        next_cycle();
        next_cycle();                       // Last word reaches the checker
    endtask

    // Comparing process, samples mid cycle
    always @(negedge RST_IN)
    begin
        if (CLK_IN)
        begin
            exp_ok   = 1'b0;
            mdl_scrm = dptx_pkg::SCRM_SEED;
        end
        else
        begin
            if (exp_ok)
            begin
                assert (lane_vld_out == exp_vld)
                else report("lane_vld_out", 32'(lane_vld_out), 32'(exp_vld), err_cmp);
                if (exp_vld)
                begin
                    assert (lane_dat_out == exp_dat)
                    else report("lane_dat_out", lane_dat_out, exp_dat, err_cmp);
                end
                assert (msg_out == exp_msg)
                else report("msg_out", 32'(msg_out), 32'(exp_msg), err_cmp);
            end
            scrm_res = scrm_model(mdl_scrm);
            exp_dat  = '0;
            for (int l = 0; l < 4; l++)
            begin
                if (l < ((mdl_ctl.lanes == 2'd3) ? 4 : int'(mdl_ctl.lanes)))
                    exp_dat[l*8 +: 8] = lane_dat_in[l*8 +: 8] ^
                        ((mdl_ctl.scrm_en && !mdl_ctl.trn_sel) ? scrm_res[23:16] : 8'h00);
            end
            exp_vld = lane_vld_in;
            exp_msg = msg_in;
            if (mdl_ctl.trn_sel || !mdl_ctl.scrm_en)
                mdl_scrm = dptx_pkg::SCRM_SEED;     // Held at seed
            else if (lane_vld_in)
                mdl_scrm = scrm_res[15:0];
            exp_ok = 1'b1;
        end
    end

    initial
    begin
        logic [31:0] t;
        CLK_IN      = 1'b1;
        msg_in      = '0;
        lane_dat_in = '0;
        lane_vld_in = 1'b1;                 // High under reset, output must stay low
        repeat (7) @(posedge RST_IN);
        #1;
        assert (!lane_vld_out)
        else report("lane_vld_out", 32'(lane_vld_out), 32'h0, err_main);
        lane_vld_in = 1'b0;
        next_cycle();
        CLK_IN = 1'b0;                      // Released after eight cycles
        next_cycle();
        assert (ctl == '0)
        else report("ctl", 32'(ctl), 32'h0, err_main);

        repeat (3)                          // Random mask, then random control word
        begin
            t          = rnd(7);
            payload[0] = {9'h000, t[6:0]};
            t          = rnd(16);
            payload[1] = t[15:0];
            write_regs(2);
        end

        for (int i = 0; i < 3; i++)         // Another ID, ctl must hold
        begin
            t          = rnd(16);
            payload[i] = t[15:0];
        end
        send_msg(8'd5, 3);
        for (int i = 0; i < 4; i++)
        begin
            assert (ctl == mdl_ctl)
            else report("ctl", 32'(ctl), 32'(mdl_ctl), err_main);
            next_cycle();
        end

        payload[0] = {9'h000, mdl_msk};     // VC lengths, other registers kept
        payload[1] = {9'h000, mdl_reg};
        t          = rnd(16);
        payload[2] = t[15:0];
        write_regs(3);

        for (int n = 0; n < 4; n++)         // Lane gating, scrambler off
        begin
            payload[0] = 16'h007f;
            payload[1] = 16'(n);
            write_regs(2);
            drive_lanes(6, 1'b0);
        end

        payload[1] = 16'h0043;              // Four lanes, scrambler on
        write_regs(2);
        drive_lanes(12, 1'b1);
        payload[1] = 16'h0047;              // Training select, back to seed
        write_regs(2);
        drive_lanes(4, 1'b1);
        payload[1] = 16'h0043;
        write_regs(2);
        drive_lanes(12, 1'b1);

        $display("Errors %0d, lane and chain errors %0d, timeouts %0d", err_main, err_cmp, tmo);
        if (err_main == 0 && err_cmp == 0 && tmo == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// ==== project.f ====
dptx_pkg.sv
dp_msg_egress.sv
dptx_ctl.sv
dptx_lane_scrm.sv
dptx_top.sv
dptx_asserts.sv
tb_dptx.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_dptx -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_dptx)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1
